/* alu_testdata.txt */
// op w sel_imm carry op0 op1 imm dout flags, all hex
// carry 0 clears C first, 1 sets C first, 2 keeps the previous flags; flags is S Z 0 H 0 V N C
01 1 0 0 0000007f 00000001 00000000 00000080 94
01 2 0 0 1234ffff 00000001 00000000 12340000 51
02 4 0 2 ffffffff 00000000 00000000 00000000 51
02 1 0 1 00000010 00000020 00000000 00000031 00
03 1 0 0 00000010 00000020 00000000 000000f0 83
04 2 0 2 00008000 00000000 00000000 00007fff 16
05 4 0 0 00000005 00000005 00000000 00007fff 42
06 1 0 0 00000001 00000000 00000000 000000ff 93
06 1 0 0 00000080 00000000 00000000 00000080 87
00 2 1 2 aaaa0000 00000000 12345678 aaaa5678 87
07 1 1 1 000000f3 000000ff 0000003c 00000030 14
08 2 1 0 12340f00 00000000 000000f1 12340ff1 00
09 4 0 0 80000001 00000003 00000000 80000002 80
09 1 1 0 00000055 00000000 00000055 00000000 44
0a 2 1 0 ffff0000 00000000 00001234 ffffedcb 56
0f 1 0 0 00000081 00000000 00000000 00000003 05
10 2 0 0 00000001 00000000 00000000 00008000 81
11 4 0 1 40000000 00000000 00000000 80000001 80
12 1 0 2 00000001 00000000 00000000 00000000 45
12 1 0 1 00000002 00000000 00000000 00000081 84
13 2 0 0 0000c000 00000000 00000000 00008000 81
14 1 0 0 ffffff82 00000000 00000000 ffffffc1 80
15 4 0 0 80000000 00000000 00000000 00000000 45
16 2 0 0 00008001 00000000 00000000 00004000 01
18 2 1 0 00000000 00000000 0000000c 00001000 00
19 1 0 1 000000ff 00000003 00000000 000000f7 01
1a 4 1 2 12345678 00000000 00000000 12345679 01
17 2 0 0 00000010 00000004 00000000 12345679 10
17 1 0 2 00000010 00000003 00000000 12345679 50
0e 1 0 1 00000000 00000000 00000000 12345679 40
17 1 0 0 00000001 00000000 00000000 12345679 10
0e 2 0 2 00000000 00000000 00000000 12345679 11
0d 1 0 2 00000000 00000000 00000000 12345679 10
0b 1 0 0 00000000 00000000 00000000 12345679 01
0c 1 0 1 00000000 00000000 00000000 12345679 00

/* flist.f */
alu_pkg.sv
alu_arith.sv
alu_shift.sv
alu_flag_reg.sv
alu_top.sv
alu_asserts.sv
tb_alu.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu \
    -f flist.f -o tb_alu_sim
./obj_dir/tb_alu_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb_alu.sv */
`timescale 1ns/1ps

module tb_alu
    import alu_pkg::*;
;

    localparam int n_vec      = 35;       // lines in the data file
    localparam int n_cols     = 9;
    localparam int n_rand     = 24;
    localparam int wait_limit = 20;       // cycles per wait loop

    logic              clk;
    logic              rst;
    alu_op_t           op;
    width_t            w;
    logic              sel_imm;
    logic [data_w-1:0] op0;
    logic [data_w-1:0] op1;
    logic [data_w-1:0] imm;
    logic [data_w-1:0] dout;
    logic [7:0]        flags;
    width_t            alu_we;

    logic [31:0] tv [0:n_vec*n_cols-1];
    logic [31:0] rnd;
    int          checks;
    int          errors;
    logic        timed_out;

    alu_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .op      (op),
        .w       (w),
        .sel_imm (sel_imm),
        .op0     (op0),
        .op1     (op1),
        .imm     (imm),
        .dout    (dout),
        .flags   (flags),
        .alu_we  (alu_we)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected {flag byte, dout} for ADD or XOR
    function automatic logic [39:0] add_xor_ref(input logic is_add, input width_t wd,
                                                input logic [31:0] a, input logic [31:0] b);
        int          n;
        logic [31:0] m;
        logic [32:0] s;
        logic [31:0] r;
        logic        h;
        logic        v;
        logic        c;
        n = wd[0] ? 8 : wd[1] ? 16 : 32;
        m = wd[0] ? 32'h0000_00ff : wd[1] ? 32'h0000_ffff : 32'hffff_ffff;
        if (is_add) begin
            s = {1'b0, a & m} + {1'b0, b & m};
            r = s[31:0];
            c = s[n];
            h = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
            v = (a[n-1] == b[n-1]) && (r[n-1] != a[n-1]);
        end else begin
            r = a ^ b;
            c = 1'b0;
            h = 1'b0;
            v = wd[0] ? ~^r[7:0] : ~^r[15:0];
        end
        return {r[n-1], (r & m) == 32'd0, 1'b0, h, 1'b0, v, 1'b0, c, (a & ~m) | (r & m)};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_alu_we(input width_t want, input string what);
        int cycles;
        cycles = 0;
        while (alu_we !== want && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (alu_we !== want) begin
            $display("timeout: alu_we stayed %b while waiting for %s", alu_we, what);
            timed_out = 1'b1;
        end
    endtask

    // one operation followed by an idle cycle
    task automatic issue(input alu_op_t o, input width_t wd, input logic si,
                         input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
        if (!timed_out) begin
            op      = o;
            w       = wd;
            sel_imm = si;
            op0     = a;
            op1     = b;
            imm     = c;
            wait_alu_we(wd, "the operation");
            w = '0;
            wait_alu_we('0, "the idle cycle");
        end
    endtask

    task automatic verify_reset();
        int bad_before;
        bad_before = errors;
        check_value("reset dout", dout, 32'd0);
        check_value("reset flags", {24'd0, flags}, 32'd0);
        check_value("reset alu_we", {29'd0, alu_we}, 32'd0);
        $display("reset state: %s", (errors == bad_before) ? "ok" : "mismatch");
    endtask

    task automatic replay_vectors();
        int b;
        int bad_before;
        for (int i = 0; i < n_vec && !timed_out; i++) begin
            b          = i * n_cols;
            bad_before = errors;
            if (tv[b+3] == 32'd0) begin
                issue(alu_rcf, 3'b001, 1'b0, '0, '0, '0);
            end else if (tv[b+3] == 32'd1) begin
                issue(alu_scf, 3'b001, 1'b0, '0, '0, '0);
            end
            issue(alu_op_t'(tv[b][4:0]), width_t'(tv[b+1][2:0]), tv[b+2][0],
                  tv[b+4], tv[b+5], tv[b+6]);
            if (!timed_out) begin
                check_value($sformatf("vector %0d dout", i), dout, tv[b+7]);
                check_value($sformatf("vector %0d flags", i), {24'd0, flags}, tv[b+8]);
                $display("vector %0d %s w=%b: %s", i, op.name(), tv[b+1][2:0],
                         (errors == bad_before) ? "ok" : "mismatch");
            end
        end
    endtask

    // each check sees the op issued one cycle before
    task automatic random_back_to_back();
        int          bad_before;
        logic [39:0] exp_q;
        width_t      prev_w;
        logic        is_add;
        width_t      wd;
        bad_before = errors;
        exp_q      = '0;
        prev_w     = '0;
        for (int i = 0; i <= n_rand; i++) begin
            if (i > 0) begin
                check_value($sformatf("random %0d dout", i - 1), dout, exp_q[31:0]);
                check_value($sformatf("random %0d flags", i - 1), {24'd0, flags},
                            {24'd0, exp_q[39:32]});
                check_value($sformatf("random %0d alu_we", i - 1), {29'd0, alu_we},
                            {29'd0, prev_w});
            end
            if (i < n_rand) begin
                rnd     = xorshift(rnd);
                is_add  = rnd[0];
                wd      = (rnd[2:1] == 2'd0) ? 3'b001 : (rnd[2:1] == 2'd1) ? 3'b010 : 3'b100;
                sel_imm = rnd[3];
                op      = is_add ? alu_add : alu_xor;
                w       = wd;
                rnd     = xorshift(rnd);
                op0     = rnd;
                rnd     = xorshift(rnd);
                op1     = rnd;
                rnd     = xorshift(rnd);
                imm     = rnd;
                exp_q   = add_xor_ref(is_add, wd, op0, sel_imm ? imm : op1);
                prev_w  = wd;
            end else begin
                w = '0;
            end
            @(negedge clk);
        end
        $display("random add/xor, %0d ops: %s", n_rand,
                 (errors == bad_before) ? "ok" : "mismatch");
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        op        = alu_move;
        w         = '0;
        sel_imm   = 1'b0;
        op0       = '0;
        op1       = '0;
        imm       = '0;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        rnd       = 32'h5eaa;
        $readmemh("alu_testdata.txt", tv);
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        verify_reset();
        replay_vectors();
        if (!timed_out) begin
            random_back_to_back();
        end
        errors = errors + dut_i.asserts_i.fail_count;
        $display("checks run: %0d, failed: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* alu_asserts.sv */
`timescale 1ns/1ps

module alu_asserts
    import alu_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input width_t     w,
    input width_t     alu_we,
    input logic [7:0] flags
);

    int fail_count = 0;                   // read by the testbench at the end

    idle_clears_we: assert property (@(posedge clk) disable iff (rst)
        (w == '0) |=> (alu_we == '0))
        else begin
            $error("alu_we nonzero one cycle after an idle cycle");
            fail_count++;
        end

    // unused positions of the flag byte
    flag_gaps_zero: assert property (@(posedge clk) disable iff (rst)
        (flags[5] == 1'b0) && (flags[3] == 1'b0))
        else begin
            $error("flag byte bit 5 or bit 3 is set");
            fail_count++;
        end

endmodule

bind alu_top alu_asserts asserts_i (
    .clk    (clk),
    .rst    (rst),
    .w      (w),
    .alu_we (alu_we),
    .flags  (flags)
);

/* alu_top.sv */
`timescale 1ns/1ps

module alu_top
    import alu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  alu_op_t           op,
    input  width_t            w,          // zero means idle
    input  logic              sel_imm,
    input  logic [data_w-1:0] op0,
    input  logic [data_w-1:0] op1,
    input  logic [data_w-1:0] imm,
    output logic [data_w-1:0] dout,
    output logic [7:0]        flags,
    output width_t            alu_we
);

    logic [data_w-1:0] op2;
    flag_bits_t        flags_q;
    logic              arith_hit;
    logic [data_w-1:0] arith_result;
    logic              arith_result_we;
    flag_bits_t        arith_flags_nx;
    flag_bits_t        arith_flags_mask;
    logic              shift_hit;
    logic [data_w-1:0] shift_result;
    logic              shift_result_we;
    flag_bits_t        shift_flags_nx;
    flag_bits_t        shift_flags_mask;

    assign op2 = sel_imm ? imm : op1;     // source operand

    alu_arith arith_i (
        .op         (op),
        .w          (w),
        .op0        (op0),
        .op2        (op2),
        .flags      (flags_q),
        .hit        (arith_hit),
        .result     (arith_result),
        .result_we  (arith_result_we),
        .flags_nx   (arith_flags_nx),
        .flags_mask (arith_flags_mask)
    );

    alu_shift shift_i (
        .op         (op),
        .w          (w),
        .op0        (op0),
        .op2        (op2),
        .flags      (flags_q),
        .hit        (shift_hit),
        .result     (shift_result),
        .result_we  (shift_result_we),
        .flags_nx   (shift_flags_nx),
        .flags_mask (shift_flags_mask)
    );

    alu_flag_reg flag_reg_i (
        .clk              (clk),
        .rst              (rst),
        .w                (w),
        .arith_hit        (arith_hit),
        .arith_result     (arith_result),
        .arith_result_we  (arith_result_we),
        .arith_flags_nx   (arith_flags_nx),
        .arith_flags_mask (arith_flags_mask),
        .shift_hit        (shift_hit),
        .shift_result     (shift_result),
        .shift_result_we  (shift_result_we),
        .shift_flags_nx   (shift_flags_nx),
        .shift_flags_mask (shift_flags_mask),
        .flags            (flags),
        .flags_q          (flags_q),
        .dout             (dout),
        .alu_we           (alu_we)
    );

endmodule

/* alu_flag_reg.sv */
`timescale 1ns/1ps

module alu_flag_reg
    import alu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  width_t            w,
    input  logic              arith_hit,
    input  logic [data_w-1:0] arith_result,
    input  logic              arith_result_we,
    input  flag_bits_t        arith_flags_nx,
    input  flag_bits_t        arith_flags_mask,
    input  logic              shift_hit,
    input  logic [data_w-1:0] shift_result,
    input  logic              shift_result_we,
    input  flag_bits_t        shift_flags_nx,
    input  flag_bits_t        shift_flags_mask,
    output logic [7:0]        flags,      // S Z 0 H 0 V N C
    output flag_bits_t        flags_q,
    output logic [data_w-1:0] dout,
    output width_t            alu_we
);

    logic              hit;
    logic [data_w-1:0] sel_result;
    logic              sel_we;
    flag_bits_t        sel_nx;
    flag_bits_t        sel_mask;

    // at most one unit claims the op
    always_comb begin
        hit = arith_hit | shift_hit;
        if (shift_hit) begin
            sel_result = shift_result;
            sel_we     = shift_result_we;
            sel_nx     = shift_flags_nx;
            sel_mask   = shift_flags_mask;
        end else begin
            sel_result = arith_result;
            sel_we     = arith_result_we;
            sel_nx     = arith_flags_nx;
            sel_mask   = arith_flags_mask;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout    <= '0;
            flags_q <= '0;
            alu_we  <= '0;
        end else begin
            alu_we <= w;                  // byte enables for the register file
            if (hit && sel_we) begin
                dout <= sel_result;
            end
            if (hit) begin
                flags_q <= (flags_q & ~sel_mask) | (sel_nx & sel_mask);  // masked update
            end
        end
    end

    assign flags = {
        flags_q[flag_s],
        flags_q[flag_z],
        1'b0,
        flags_q[flag_h],
        1'b0,
        flags_q[flag_v],
        flags_q[flag_n],
        flags_q[flag_c]
    };

endmodule

/* alu_shift.sv */
`timescale 1ns/1ps

module alu_shift
    import alu_pkg::*;
(
    input  alu_op_t           op,
    input  width_t            w,
    input  logic [data_w-1:0] op0,        // value to shift
    input  logic [data_w-1:0] op2,        // bit number in [3:0]
    input  flag_bits_t        flags,
    output logic              hit,
    output logic [data_w-1:0] result,
    output logic              result_we,
    output flag_bits_t        flags_nx,
    output flag_bits_t        flags_mask
);

    logic [4:0]        msb;               // top bit at this width
    logic              lsb_in;
    logic              msb_in;
    logic [data_w-1:0] shl;
    logic [data_w-1:0] shr;
    logic [3:0]        bit_idx;
    logic [data_w-1:0] res;
    logic              c_out;

    // bits shifted in at either end
    always_comb begin
        msb    = top_bit(w);
        lsb_in = 1'b0;
        msb_in = 1'b0;
        case (op)
            alu_rlc: lsb_in = op0[msb];
            alu_rl:  lsb_in = flags[flag_c];
            alu_rrc: msb_in = op0[0];
            alu_rr:  msb_in = flags[flag_c];
            alu_sra: msb_in = op0[msb];    // keep sign
            default: ;
        endcase
        shl      = {op0[data_w-2:0], lsb_in};
        shr      = {1'b0, op0[data_w-1:1]};
        shr[msb] = msb_in;                 // top of the width, not of the word
    end

    assign bit_idx = op2[3:0];

    always_comb begin
        hit        = 1'b1;
        res        = op0;
        result_we  = 1'b0;
        c_out      = flags[flag_c];
        flags_nx   = flags;
        flags_mask = '0;
        case (op)
            alu_rlc, alu_rl, alu_sla, alu_sll: begin
                res       = shl;
                c_out     = op0[msb];
                result_we = 1'b1;
            end
            alu_rrc, alu_rr, alu_sra, alu_srl: begin
                res       = shr;
                c_out     = op0[0];
                result_we = 1'b1;
            end
            alu_set: begin
                res[bit_idx] = 1'b1;
                result_we    = 1'b1;
            end
            alu_res: begin
                res[bit_idx] = 1'b0;
                result_we    = 1'b1;
            end
            alu_chg: begin
                res[bit_idx] = ~op0[bit_idx];
                result_we    = 1'b1;
            end
            alu_bit: begin
                flags_nx[flag_z] = ~op0[bit_idx];
                flags_nx[flag_h] = 1'b1;
                flags_nx[flag_n] = 1'b0;
                flags_mask       = (1 << flag_z) | (1 << flag_h) | (1 << flag_n);
            end
            default: hit = 1'b0;
        endcase
        // all shifts share one flag rule
        if (op inside {alu_rlc, alu_rrc, alu_rl, alu_rr, alu_sla, alu_sra,
                       alu_sll, alu_srl}) begin
            flags_nx[flag_s] = sign_at(w, res);
            flags_nx[flag_z] = zero_at(w, res);
            flags_nx[flag_h] = 1'b0;
            flags_nx[flag_v] = even_par(w, res);
            flags_nx[flag_n] = 1'b0;
            flags_nx[flag_c] = c_out;
            flags_mask       = '1;
        end
        if (w == '0) begin
            hit = 1'b0;
        end
    end

    assign result = fit(w, op0, res);

endmodule

/* alu_arith.sv */
`timescale 1ns/1ps

module alu_arith
    import alu_pkg::*;
(
    input  alu_op_t           op,
    input  width_t            w,
    input  logic [data_w-1:0] op0,        // destination
    input  logic [data_w-1:0] op2,        // source
    input  flag_bits_t        flags,      // registered flags
    output logic              hit,
    output logic [data_w-1:0] result,
    output logic              result_we,
    output flag_bits_t        flags_nx,
    output flag_bits_t        flags_mask
);

    logic              is_sub;
    logic              cin;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] sum;
    logic              half_c;            // out of bit 3
    logic [2:0]        cc;                // out of byte, word, long
    logic [data_w:0]   ext_sum;
    logic              carry_w;
    logic              ovf;
    logic [data_w-1:0] lres;
    logic [data_w-1:0] res;

    // adder in slices so every width has its own carry
    always_comb begin
        is_sub = op inside {alu_sub, alu_sbc, alu_cp, alu_neg};
        cin    = ((op == alu_adc) || (op == alu_sbc)) && flags[flag_c];
        a      = (op == alu_neg) ? '0 : op0;  // neg is 0 - op0
        b      = (op == alu_neg) ? op0 : op2;
        if (is_sub) begin
            {half_c, sum[3:0]} = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
            {cc[0], sum[7:4]}  = {1'b0, a[7:4]} - {1'b0, b[7:4]} - {4'd0, half_c};
            {cc[1], sum[15:8]} = {1'b0, a[15:8]} - {1'b0, b[15:8]} - {8'd0, cc[0]};
            {cc[2], sum[31:16]} = {1'b0, a[31:16]} - {1'b0, b[31:16]} - {16'd0, cc[1]};
            ext_sum = sext(w, a) - sext(w, b) - {{data_w{1'b0}}, cin};
        end else begin
            {half_c, sum[3:0]} = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
            {cc[0], sum[7:4]}  = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'd0, half_c};
            {cc[1], sum[15:8]} = {1'b0, a[15:8]} + {1'b0, b[15:8]} + {8'd0, cc[0]};
            {cc[2], sum[31:16]} = {1'b0, a[31:16]} + {1'b0, b[31:16]} + {16'd0, cc[1]};
            ext_sum = sext(w, a) + sext(w, b) + {{data_w{1'b0}}, cin};
        end
        carry_w = w[0] ? cc[0] : w[1] ? cc[1] : cc[2];
        ovf     = ext_sum[data_w] ^ sign_at(w, sum);  // true sign vs truncated sign
    end

    always_comb begin
        case (op)
            alu_and: lres = op0 & op2;
            alu_or:  lres = op0 | op2;
            default: lres = op0 ^ op2;
        endcase
    end

    always_comb begin
        hit        = 1'b1;
        res        = op0;
        result_we  = 1'b0;
        flags_nx   = flags;
        flags_mask = '0;
        case (op)
            alu_move: begin
                res       = op2;
                result_we = 1'b1;
            end
            alu_add, alu_adc, alu_sub, alu_sbc, alu_cp, alu_neg: begin
                res              = sum;
                result_we        = (op != alu_cp);  // compare only
                flags_nx[flag_s] = sign_at(w, sum);
                flags_nx[flag_z] = zero_at(w, sum);
                flags_nx[flag_h] = half_c;
                flags_nx[flag_v] = ovf;
                flags_nx[flag_n] = is_sub;
                flags_nx[flag_c] = carry_w;
                flags_mask       = '1;
            end
            alu_and, alu_or, alu_xor: begin
                res              = lres;
                result_we        = 1'b1;
                flags_nx[flag_s] = sign_at(w, lres);
                flags_nx[flag_z] = zero_at(w, lres);
                flags_nx[flag_h] = (op == alu_and);
                flags_nx[flag_v] = even_par(w, lres);
                flags_nx[flag_n] = 1'b0;
                flags_nx[flag_c] = 1'b0;
                flags_mask       = '1;
            end
            alu_cpl: begin
                res              = ~op2;
                result_we        = 1'b1;
                flags_nx[flag_h] = 1'b1;
                flags_nx[flag_n] = 1'b1;
                flags_mask       = (1 << flag_h) | (1 << flag_n);
            end
            alu_scf, alu_rcf: begin
                flags_nx[flag_c] = (op == alu_scf);
                flags_nx[flag_h] = 1'b0;
                flags_nx[flag_n] = 1'b0;
                flags_mask       = (1 << flag_c) | (1 << flag_h) | (1 << flag_n);
            end
            alu_ccf, alu_zcf: begin
                flags_nx[flag_c] = (op == alu_ccf) ? ~flags[flag_c] : ~flags[flag_z];
                flags_nx[flag_n] = 1'b0;
                flags_mask       = (1 << flag_c) | (1 << flag_n);
            end
            default: hit = 1'b0;         // shift unit op
        endcase
        if (w == '0) begin
            hit = 1'b0;                  // no operation this cycle
        end
    end

    assign result = fit(w, op0, res);

endmodule

/* alu_pkg.sv */
package alu_pkg;

    localparam int data_w = 32;    // operand width
    localparam int op_w   = 5;     // operation code width
    localparam int flag_w = 6;     // live flags only

    // one-hot width code where all zero means no operation
    typedef logic [2:0] width_t;

    typedef enum logic [op_w-1:0] {
        alu_move, alu_add, alu_adc, alu_sub,             // arithmetic
        alu_sbc, alu_cp, alu_neg,
        alu_and, alu_or, alu_xor, alu_cpl,               // logic
        alu_scf, alu_rcf, alu_ccf, alu_zcf,              // flag only
        alu_rlc, alu_rrc, alu_rl, alu_rr,                // single-step shifts
        alu_sla, alu_sra, alu_sll, alu_srl,
        alu_bit, alu_set, alu_res, alu_chg               // bit number from op2
    } alu_op_t;

    typedef logic [flag_w-1:0] flag_bits_t;  // S Z H V N C

    localparam int flag_s = 5;
    localparam int flag_z = 4;
    localparam int flag_h = 3;
    localparam int flag_v = 2;
    localparam int flag_n = 1;
    localparam int flag_c = 0;

    function automatic logic [4:0] top_bit(input width_t w);
        return w[0] ? 5'd7 : w[1] ? 5'd15 : 5'd31;
    endfunction

    function automatic logic [data_w-1:0] width_mask(input width_t w);
        return w[0] ? 32'h0000_00ff : w[1] ? 32'h0000_ffff : 32'hffff_ffff;
    endfunction

    function automatic logic sign_at(input width_t w, input logic [data_w-1:0] x);
        return x[top_bit(w)];
    endfunction

    function automatic logic zero_at(input width_t w, input logic [data_w-1:0] x);
        return (x & width_mask(w)) == '0;
    endfunction

    // parity over the low byte, or the low 16 bits above byte width
    function automatic logic even_par(input width_t w, input logic [data_w-1:0] x);
        return w[0] ? ~^x[7:0] : ~^x[15:0];
    endfunction

    function automatic logic [data_w:0] sext(input width_t w, input logic [data_w-1:0] x);
        return w[0] ? {{25{x[7]}}, x[7:0]} :
               w[1] ? {{17{x[15]}}, x[15:0]} : {x[31], x};
    endfunction

    // bits above the width keep the destination value
    function automatic logic [data_w-1:0] fit(input width_t w, input logic [data_w-1:0] dst,
                                              input logic [data_w-1:0] val);
        return (val & width_mask(w)) | (dst & ~width_mask(w));
    endfunction

endpackage
